//--- source/udp_tx_settings.svh
/*
  widths, depths and protocol constants for the UDP transmit block
  include wherever a port width or a constant is needed
*/
`ifndef UDP_TX_SETTINGS_SVH
`define UDP_TX_SETTINGS_SVH

// field widths
`define UDP_IP_W          32
`define UDP_PORT_W        16
`define UDP_BYTE_W        8

// frame layout
`define UDP_HDR_BYTES     8
`define UDP_MIN_BYTES     26    // short frames padded up to this
`define UDP_PROTO         17    // ip protocol number for udp

// buffering
`define UDP_PAYLOAD_DEPTH 64
`define UDP_DESC_DEPTH    4
`define UDP_MAX_PAYLOAD   40

`endif

//--- source/udp_tx_pkg.sv
/*
  shared types of the UDP transmit block
  static config, per-packet descriptor and the output byte stream
*/
`include "udp_tx_settings.svh"

package udp_tx_pkg;

  // addresses and ports, held stable by the producer
  typedef struct packed {
    logic [`UDP_IP_W-1:0]   src_ip;
    logic [`UDP_IP_W-1:0]   dst_ip;
    logic [`UDP_PORT_W-1:0] src_port;
    logic [`UDP_PORT_W-1:0] dst_port;
  } udp_cfg_t;

  // one entry per packet, checksum engine to sender
  typedef struct packed {
    logic [`UDP_PORT_W-1:0] udp_len;   // payload + header
    logic [`UDP_PORT_W-1:0] checksum;  // already complemented
  } udp_desc_t;

  // byte stream towards the ip layer
  typedef struct packed {
    logic                   valid;
    logic                   last;
    logic [`UDP_BYTE_W-1:0] data;
  } udp_stream_t;

endpackage

//--- source/sync_fifo.sv
/*
  single clock fifo, first word fall through
  head shows the oldest word while empty is low, pop removes it
*/
module sync_fifo #(
  parameter int width = 8,
  parameter int depth = 16
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push,
  input  logic [width-1:0] push_data,
  input  logic             pop,
  output logic [width-1:0] head,
  output logic             empty,
  output logic             full
);

  localparam int addr_w = (depth > 1) ? $clog2(depth) : 1;

  logic [width-1:0]  mem [depth];
  logic [addr_w-1:0] wr_ptr;
  logic [addr_w-1:0] rd_ptr;
  logic [addr_w:0]   count;
  logic              do_push;
  logic              do_pop;

  assign do_push = push && !full;   // overflow dropped
  assign do_pop  = pop && !empty;

  assign empty = (count == '0);
  assign full  = (count == (addr_w+1)'(depth));
  assign head  = mem[rd_ptr];

  // storage
  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  // pointers and fill level
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == addr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == addr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

endmodule

//--- source/udp_checksum.sv
/*
  udp checksum engine
  takes a length over a four-phase handshake, sums the written payload
  bytes with pseudo header and udp header, then pushes {udp_len, checksum}
*/
`include "udp_tx_settings.svh"

module udp_checksum (
  input  logic                    clk,
  input  logic                    rst_n,
  input  udp_tx_pkg::udp_cfg_t    cfg,
  input  logic                    pkt_req,
  input  logic [`UDP_PORT_W-1:0]  pkt_len,
  output logic                    pkt_ack,
  input  logic                    wr_en,
  input  logic [`UDP_BYTE_W-1:0]  wr_data,
  input  logic                    desc_full,
  output logic                    desc_push,
  output udp_tx_pkg::udp_desc_t   desc
);

  typedef enum logic [2:0] {
    st_idle,
    st_ack,
    st_accum,
    st_fold,
    st_push
  } ck_state_t;

  ck_state_t              state;
  logic [`UDP_PORT_W-1:0] pay_len;
  logic [`UDP_PORT_W-1:0] udp_len;
  logic [`UDP_PORT_W-1:0] udp_len_next;
  logic [`UDP_PORT_W-1:0] byte_cnt;
  logic [`UDP_BYTE_W-1:0] hi_byte;     // first byte of a pair
  logic [31:0]            sum;
  logic [31:0]            seed_sum;
  logic                   accept;
  logic                   take_byte;
  logic                   last_byte;

  assign udp_len_next = pkt_len + `UDP_PORT_W'(`UDP_HDR_BYTES);

  // fifo space is checked here, one packet in flight at most
  assign accept    = (state == st_idle) && pkt_req && !desc_full;
  assign take_byte = wr_en && ((state == st_ack) || (state == st_accum));
  assign last_byte = (byte_cnt == pay_len - 1'b1);

  ////////////////////
  // pseudo header and udp header words
  ////////////////////

  always_comb
  begin
    seed_sum = 32'(cfg.src_ip[31:16]) + 32'(cfg.src_ip[15:0])
             + 32'(cfg.dst_ip[31:16]) + 32'(cfg.dst_ip[15:0])
             + 32'(`UDP_PROTO)
             + 32'(udp_len_next)          // pseudo header length
             + 32'(udp_len_next)          // udp header length field
             + 32'(cfg.src_port) + 32'(cfg.dst_port);
  end

  ////////////////////
  // control
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= st_idle;
      pkt_ack  <= 1'b0;
      byte_cnt <= '0;
    end
    else
    begin
      if (take_byte)
        byte_cnt <= byte_cnt + 1'b1;

      case (state)
        st_idle:
        begin
          if (accept)
          begin
            pkt_ack  <= 1'b1;
            byte_cnt <= '0;
            state    <= st_ack;
          end
        end
        st_ack:
        begin
          if (!pkt_req)           // producer released, finish handshake
          begin
            pkt_ack <= 1'b0;
            state   <= st_accum;
          end
        end
        st_accum:
        begin
          if (byte_cnt == pay_len)
            state <= st_fold;
        end
        st_fold:
        begin
          if (sum[31:16] == '0)
            state <= st_push;
        end
        st_push:
          state <= st_idle;       // single push cycle
        default:
          state <= st_idle;
      endcase
    end
  end

  ////////////////////
  // sum datapath
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      pay_len <= pkt_len;
      udp_len <= udp_len_next;
      sum     <= seed_sum;
    end
    else if (take_byte)
    begin
      if (!byte_cnt[0])
      begin
        hi_byte <= wr_data;
        if (last_byte)            // odd length, low half is zero
          sum <= sum + {16'h0, wr_data, 8'h00};
      end
      else
        sum <= sum + {16'h0, hi_byte, wr_data};
    end
    else if ((state == st_fold) && (sum[31:16] != '0))
      sum <= {16'h0, sum[31:16]} + {16'h0, sum[15:0]};  // end-around carry
  end

  assign desc_push     = (state == st_push);
  assign desc.udp_len  = udp_len;
  assign desc.checksum = ~sum[15:0];

endmodule

//--- source/udp_sender.sv
/*
  udp frame sender
  pops one descriptor, requests the ip layer, waits for tx_start,
  then streams header, payload and zero padding without gaps
*/
`include "udp_tx_settings.svh"

module udp_sender (
  input  logic                    clk,
  input  logic                    rst_n,
  input  udp_tx_pkg::udp_cfg_t    cfg,
  input  udp_tx_pkg::udp_desc_t   desc,
  input  logic                    desc_empty,
  output logic                    desc_pop,
  input  logic [`UDP_BYTE_W-1:0]  pay_data,
  output logic                    pay_pop,
  output logic                    ip_req,
  input  logic                    ip_ack,
  input  logic                    tx_start,
  output logic                    tx_ready,
  output udp_tx_pkg::udp_stream_t tx
);

  typedef enum logic [2:0] {
    st_idle,
    st_ip_req,
    st_ip_rel,
    st_ready,
    st_send
  } tx_state_t;

  tx_state_t              state;
  logic [`UDP_PORT_W-1:0] udp_len;
  logic [`UDP_PORT_W-1:0] checksum;
  logic [`UDP_PORT_W-1:0] total_len;   // udp_len or the minimum
  logic [`UDP_PORT_W-1:0] byte_cnt;
  logic [`UDP_BYTE_W-1:0] tx_byte;
  logic                   load_byte;

  assign desc_pop = (state == st_idle) && !desc_empty;

  assign total_len = (udp_len < `UDP_PORT_W'(`UDP_MIN_BYTES)) ?
                     `UDP_PORT_W'(`UDP_MIN_BYTES) : udp_len;

  // one byte per cycle from tx_start until total_len
  assign load_byte = ((state == st_ready) && tx_start) ||
                     ((state == st_send) && (byte_cnt < total_len));

  // payload head consumed while it is being sent
  assign pay_pop = (state == st_send) &&
                   (byte_cnt >= `UDP_PORT_W'(`UDP_HDR_BYTES)) &&
                   (byte_cnt < udp_len);

  ////////////////////
  // byte select
  ////////////////////

  always_comb
  begin
    case (byte_cnt)
      16'd0:   tx_byte = cfg.src_port[15:8];
      16'd1:   tx_byte = cfg.src_port[7:0];
      16'd2:   tx_byte = cfg.dst_port[15:8];
      16'd3:   tx_byte = cfg.dst_port[7:0];
      16'd4:   tx_byte = udp_len[15:8];
      16'd5:   tx_byte = udp_len[7:0];
      16'd6:   tx_byte = checksum[15:8];
      16'd7:   tx_byte = checksum[7:0];
      default: tx_byte = (byte_cnt < udp_len) ? pay_data : '0;  // zero pad
    endcase
  end

  // descriptor fields, loaded on pop
  always_ff @(posedge clk)
  begin
    if (desc_pop)
    begin
      udp_len  <= desc.udp_len;
      checksum <= desc.checksum;
    end
  end

  ////////////////////
  // handshakes and stream
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= st_idle;
      ip_req   <= 1'b0;
      tx_ready <= 1'b0;
      byte_cnt <= '0;
      tx       <= '0;
    end
    else
    begin
      if (load_byte)
      begin
        tx.valid <= 1'b1;
        tx.last  <= (byte_cnt == total_len - 1'b1);
        tx.data  <= tx_byte;
        byte_cnt <= byte_cnt + 1'b1;
      end
      else
        tx <= '0;

      case (state)
        st_idle:
        begin
          byte_cnt <= '0;
          if (!desc_empty)
          begin
            ip_req <= 1'b1;
            state  <= st_ip_req;
          end
        end
        st_ip_req:
        begin
          if (ip_ack)
          begin
            ip_req <= 1'b0;
            state  <= st_ip_rel;
          end
        end
        st_ip_rel:
        begin
          if (!ip_ack)            // slot granted and released
          begin
            tx_ready <= 1'b1;
            state    <= st_ready;
          end
        end
        st_ready:
        begin
          if (tx_start)
          begin
            tx_ready <= 1'b0;
            state    <= st_send;
          end
        end
        st_send:
        begin
          if (byte_cnt == total_len)   // last byte already out
            state <= st_idle;
        end
        default:
          state <= st_idle;
      endcase
    end
  end

endmodule

//--- source/udp_tx.sv
/*
  udp transmit top level
  checksum engine and byte fifo on the producer side,
  descriptor fifo between them, sender on the ip side
*/
`include "udp_tx_settings.svh"

module udp_tx (
  input  logic                    clk,
  input  logic                    rst_n,
  input  udp_tx_pkg::udp_cfg_t    cfg,
  input  logic                    pkt_req,
  input  logic [`UDP_PORT_W-1:0]  pkt_len,
  output logic                    pkt_ack,
  input  logic                    wr_en,
  input  logic [`UDP_BYTE_W-1:0]  wr_data,
  output logic                    payload_full,
  output logic                    ip_req,
  input  logic                    ip_ack,
  input  logic                    tx_start,
  output logic                    tx_ready,
  output udp_tx_pkg::udp_stream_t tx
);

  udp_tx_pkg::udp_desc_t  desc_in;     // engine to fifo
  udp_tx_pkg::udp_desc_t  desc_head;   // fifo to sender
  logic                   desc_push;
  logic                   desc_pop;
  logic                   desc_empty;
  logic                   desc_full;
  logic [`UDP_BYTE_W-1:0] pay_head;
  logic                   pay_pop;

  udp_checksum udp_checksum_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg       (cfg),
    .pkt_req   (pkt_req),
    .pkt_len   (pkt_len),
    .pkt_ack   (pkt_ack),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .desc_full (desc_full),
    .desc_push (desc_push),
    .desc      (desc_in)
  );

  // payload bytes wait here until sent
  sync_fifo #(
    .width (`UDP_BYTE_W),
    .depth (`UDP_PAYLOAD_DEPTH)
  ) payload_fifo_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (wr_en),
    .push_data (wr_data),
    .pop       (pay_pop),
    .head      (pay_head),
    .empty     (),
    .full      (payload_full)
  );

  sync_fifo #(
    .width ($bits(udp_tx_pkg::udp_desc_t)),
    .depth (`UDP_DESC_DEPTH)
  ) desc_fifo_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (desc_push),
    .push_data (desc_in),
    .pop       (desc_pop),
    .head      (desc_head),
    .empty     (desc_empty),
    .full      (desc_full)
  );

  udp_sender udp_sender_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg        (cfg),
    .desc       (desc_head),
    .desc_empty (desc_empty),
    .desc_pop   (desc_pop),
    .pay_data   (pay_head),
    .pay_pop    (pay_pop),
    .ip_req     (ip_req),
    .ip_ack     (ip_ack),
    .tx_start   (tx_start),
    .tx_ready   (tx_ready),
    .tx         (tx)
  );

endmodule

//--- dv/udp_tx_model.svh
/*
  reference model for the udp transmit testbench, included inside the tb module
  lcg for stimulus, udp checksum and the expected frame bytes
*/
`ifndef UDP_TX_MODEL_SVH
`define UDP_TX_MODEL_SVH

typedef logic [8*`UDP_MAX_PAYLOAD-1:0] payload_t;   // byte k at [8*k +: 8]

function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// bytes on the wire, short frames padded
function automatic int frame_length(input int pay_len);
  if (pay_len + `UDP_HDR_BYTES < `UDP_MIN_BYTES)
    return `UDP_MIN_BYTES;
  return pay_len + `UDP_HDR_BYTES;
endfunction

////////////////////
// checksum over pseudo header, udp header and payload
////////////////////

function automatic logic [15:0] expected_checksum(
  input udp_tx_pkg::udp_cfg_t c,
  input int                   pay_len,
  input payload_t             pay
);
  logic [31:0] acc;
  logic [15:0] udp_len;
  logic [7:0]  lo;
  int          k;
  udp_len = 16'(pay_len + `UDP_HDR_BYTES);
  acc = 32'(c.src_ip[31:16]) + 32'(c.src_ip[15:0]);
  acc = acc + 32'(c.dst_ip[31:16]) + 32'(c.dst_ip[15:0]);
  acc = acc + 32'(`UDP_PROTO) + 32'(udp_len);                    // pseudo header
  acc = acc + 32'(c.src_port) + 32'(c.dst_port) + 32'(udp_len);  // checksum field zero
  for (k = 0; k < pay_len; k += 2)
  begin
    lo  = (k + 1 < pay_len) ? pay[8*(k+1) +: 8] : 8'h00;        // odd tail padded
    acc = acc + {16'h0, pay[8*k +: 8], lo};
  end
  while (acc[31:16] != 16'h0)
    acc = {16'h0, acc[31:16]} + {16'h0, acc[15:0]};
  return ~acc[15:0];
endfunction

// one byte of the expected frame
function automatic logic [7:0] frame_byte(
  input udp_tx_pkg::udp_cfg_t c,
  input int                   pay_len,
  input logic [15:0]          csum,
  input payload_t             pay,
  input int                   idx
);
  logic [15:0] udp_len;
  logic [63:0] header;
  udp_len = 16'(pay_len + `UDP_HDR_BYTES);
  header  = {c.src_port, c.dst_port, udp_len, csum};
  if (idx < `UDP_HDR_BYTES)
    return header[8*(7-idx) +: 8];   // network order
  else if (idx < pay_len + `UDP_HDR_BYTES)
    return pay[8*(idx-`UDP_HDR_BYTES) +: 8];
  return 8'h00;
endfunction

`endif

//--- dv/udp_tx_tb.sv
/*
  testbench for the udp transmit block
  sends packets over the length handshake, answers the ip and start
  handshakes with random delays and checks each frame against the model
*/
`include "udp_tx_settings.svh"

module udp_tx_tb;

  timeunit 1ns;
  timeprecision 100ps;

  `include "udp_tx_model.svh"

  localparam int clk_period = 100;
  localparam int n_packets  = 11;   // frames over all tests

  logic                    clk = 1'b0;
  logic                    rst_n;
  udp_tx_pkg::udp_cfg_t    cfg;
  logic                    pkt_req;
  logic [`UDP_PORT_W-1:0]  pkt_len;
  logic                    pkt_ack;
  logic                    wr_en;
  logic [`UDP_BYTE_W-1:0]  wr_data;
  logic                    payload_full;
  logic                    ip_req;
  logic                    ip_ack;
  logic                    tx_start;
  logic                    tx_ready;
  udp_tx_pkg::udp_stream_t tx;

  logic [31:0] seed = 32'h6560_22e4;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          frames_done;
  int          delay_max;    // upper bound of handshake delays
  int          pushes;       // bytes written into the byte fifo
  logic        hold_start;
  logic        started;      // tx_start seen for the current frame
  int          exp_len_q[$];
  payload_t    exp_pay_q[$];

  udp_tx dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg          (cfg),
    .pkt_req      (pkt_req),
    .pkt_len      (pkt_len),
    .pkt_ack      (pkt_ack),
    .wr_en        (wr_en),
    .wr_data      (wr_data),
    .payload_full (payload_full),
    .ip_req       (ip_req),
    .ip_ack       (ip_ack),
    .tx_start     (tx_start),
    .tx_ready     (tx_ready),
    .tx           (tx)
  );

  initial
  begin
    forever
      #(clk_period / 2) clk = ~clk;
  end

  function int rand_below(input int n);
    seed = lcg_next(seed);
    return int'(seed[30:16]) % n;
  endfunction

  task report_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before)
      $display("test %s: pass", name);
    else
    begin
      tests_failed++;
      $display("test %s: fail, %0d errors", name, errors - err_before);
    end
  endtask

  task check_ready_low();
    assert (!tx_ready)
    else
    begin
      $display("%0t: tx_ready raised before ip_ack fell", $time);
      errors++;
    end
  endtask

  // one packet through the producer side
  task automatic send_packet(input int len);
    payload_t pay;
    int       i;
    pay = '0;
    for (i = 0; i < len; i++)
      pay[8*i +: 8] = 8'(rand_below(256));
    exp_len_q.push_back(len);
    exp_pay_q.push_back(pay);
    @(negedge clk);
    pkt_len = 16'(len);
    pkt_req = 1'b1;
    do
      @(negedge clk);
    while (!pkt_ack);
    pkt_req = 1'b0;
    do
      @(negedge clk);
    while (pkt_ack);
    i = 0;
    while (i < len)
    begin
      wr_en   = !payload_full;   // held off while the byte fifo is full
      wr_data = pay[8*i +: 8];
      if (!payload_full)
        i++;
      @(negedge clk);
    end
    wr_en = 1'b0;
  endtask

  ////////////////////
  // ip layer and downstream
  ////////////////////

  initial
  begin : ip_side
    int d;
    forever
    begin
      @(negedge clk);
      if (rst_n === 1'b1 && ip_req === 1'b1)
      begin
        d = rand_below(delay_max + 1);
        repeat (d)
        begin
          @(negedge clk);
          check_ready_low();
          assert (ip_req)
          else
          begin
            $display("%0t: ip_req dropped before ip_ack was given", $time);
            errors++;
          end
        end
        ip_ack = 1'b1;
        do
        begin
          @(negedge clk);
          check_ready_low();
        end
        while (ip_req);
        d = rand_below(delay_max + 1);
        repeat (d)
        begin
          @(negedge clk);
          check_ready_low();
        end
        ip_ack = 1'b0;
      end
    end
  end

  initial
  begin : start_side
    int d;
    forever
    begin
      @(negedge clk);
      if (tx_ready === 1'b1 && !hold_start)
      begin
        d = rand_below(delay_max + 1);
        repeat (d) @(negedge clk);
        tx_start = 1'b1;
        @(negedge clk);
        tx_start = 1'b0;
      end
    end
  end

  // inputs as the DUT samples them
  initial
  begin : posedge_monitor
    forever
    begin
      @(posedge clk);
      if (rst_n === 1'b1 && wr_en === 1'b1)
        pushes++;
      if (rst_n === 1'b1 && tx_start === 1'b1)
        started = 1'b1;
    end
  end

  ////////////////////
  // frame compare
  ////////////////////

  initial
  begin : compare
    int          idx;
    int          cur_len;
    int          total;
    int          pay_seen;   // payload bytes already sent
    payload_t    cur_pay;
    logic [15:0] cur_csum;
    logic [7:0]  exp_byte;
    idx      = 0;
    cur_len  = 0;
    total    = `UDP_MIN_BYTES;
    pay_seen = 0;
    cur_pay  = '0;
    cur_csum = '0;
    forever
    begin
      @(negedge clk);
      if (rst_n === 1'b1)
      begin
        if (tx.valid)
        begin
          assert (started)
          else
          begin
            $display("%0t: byte sent before tx_start", $time);
            errors++;
          end
          if (idx == 0)
          begin
            assert (exp_len_q.size() > 0)
            else
            begin
              $display("%0t: frame sent with no packet submitted", $time);
              errors++;
            end
            if (exp_len_q.size() > 0)
            begin
              cur_len  = exp_len_q.pop_front();
              cur_pay  = exp_pay_q.pop_front();
              cur_csum = expected_checksum(cfg, cur_len, cur_pay);
              total    = frame_length(cur_len);
            end
          end
          exp_byte = frame_byte(cfg, cur_len, cur_csum, cur_pay, idx);
          if (idx >= `UDP_HDR_BYTES && idx < cur_len + `UDP_HDR_BYTES)
            pay_seen++;   // left the byte fifo
          assert (tx.data === exp_byte)
          else
          begin
            $display("MISMATCH at %0t: byte %0d is %h, expected %h",
                     $time, idx, tx.data, exp_byte);
            errors++;
          end
          assert (tx.last === (idx == total - 1))
          else
          begin
            $display("MISMATCH at %0t: last flag %b at byte %0d of %0d",
                     $time, tx.last, idx, total);
            errors++;
          end
          idx++;
          if (tx.last || idx >= total)   // frame done
          begin
            idx     = 0;
            started = 1'b0;
            frames_done++;
          end
        end
        else
        begin
          assert (idx == 0)
          else
          begin
            $display("%0t: gap in frame after byte %0d", $time, idx - 1);
            errors++;
            idx = 0;
          end
        end
        assert (payload_full === (pushes - pay_seen == `UDP_PAYLOAD_DEPTH))
        else
        begin
          $display("MISMATCH at %0t: payload_full %b with %0d bytes waiting",
                   $time, payload_full, pushes - pay_seen);
          errors++;
        end
      end
    end
  end

  ////////////////////
  // test sequence
  ////////////////////

  initial
  begin : main_seq
    int err_before;
    int k;
    rst_n      = 1'b0;
    cfg        = {32'hc0a8_0a01, 32'hc0a8_0a64, 16'd40000, 16'd5004};
    pkt_req    = 1'b0;
    pkt_len    = '0;
    wr_en      = 1'b0;
    wr_data    = '0;
    ip_ack     = 1'b0;
    tx_start   = 1'b0;
    hold_start = 1'b0;
    started    = 1'b0;
    delay_max  = 2;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    frames_done  = 0;
    pushes       = 0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    err_before = errors;
    @(negedge clk);
    assert (!pkt_ack && !ip_req && !tx_ready && !tx.valid)
    else
    begin
      $display("MISMATCH at %0t: outputs not idle after reset", $time);
      errors++;
    end
    report_test("reset state", err_before);

    err_before = errors;
    send_packet(20);
    wait (frames_done == 1);
    report_test("even payload of 20", err_before);

    err_before = errors;
    send_packet(13);
    wait (frames_done == 2);
    report_test("odd payload of 13, padded", err_before);

    err_before = errors;
    delay_max  = 12;   // slow ip side and downstream
    send_packet(1 + rand_below(`UDP_MAX_PAYLOAD));
    wait (frames_done == 3);
    delay_max  = 2;
    report_test("late handshakes", err_before);

    // queue up descriptors while tx_start is withheld
    err_before = errors;
    hold_start = 1'b1;
    fork
      for (k = 0; k < 8; k++)
        send_packet(1 + rand_below(`UDP_MAX_PAYLOAD));
      begin
        repeat (150) @(negedge clk);
        hold_start = 1'b0;
      end
    join
    wait (frames_done == n_packets);
    report_test("eight queued packets", err_before);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  // run limit scaled by the packet count
  initial
  begin
    #(n_packets * (`UDP_MAX_PAYLOAD + 60) * clk_period);
    $display("timeout: frames did not all arrive, %0d of %0d seen", frames_done, n_packets);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

//--- compile.f
+incdir+source
+incdir+dv
source/udp_tx_pkg.sv
source/sync_fifo.sv
source/udp_checksum.sv
source/udp_sender.sv
source/udp_tx.sv
dv/udp_tx_tb.sv
